/* flist.f */
design/sp_mem_pkg.sv
design/byte_lane_ram.sv
design/lane_request_ctrl.sv
design/read_lane_align.sv
design/sp_bram.sv
test/tb_clk_gen.sv
test/sp_bram_sva.sv
test/sp_bram_tb.sv

/* Bender.yml */
package:
  name: sp_bram

sources:
  # package first, then the RTL leaves and the top level
  - files:
      - design/sp_mem_pkg.sv
      - design/byte_lane_ram.sv
      - design/lane_request_ctrl.sv
      - design/read_lane_align.sv
      - design/sp_bram.sv

  # simulation only
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/sp_bram_sva.sv
      - test/sp_bram_tb.sv

/* test/sp_bram_tb.sv */
/*
  testbench for the scratch memory
  runs directed byte, half and word traffic, bad commands and
  random commands against a byte-array model of the store
*/
module sp_bram_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW       = sp_mem_pkg::DATA_WIDTH;
    localparam int MAX_WAIT = 20;

    typedef struct packed {
        logic          is_read;
        logic          err;
        logic [DW-1:0] data;
        logic [7:0]    edges;        // rising edges from enable to ready
        logic          err_after;    // o_bus_err once enable is low
        logic          ready_after;  // o_ready after the first low-enable edge
    } bus_result_t;

    logic                                clk;
    logic                                rst_n;
    logic                                enable;
    logic                                wr_en;
    logic [sp_mem_pkg::ADDR_WIDTH-1:0]   addr;
    logic [DW-1:0]                       wdata;
    logic [sp_mem_pkg::LANES-1:0]        be;
    logic                                ready;
    logic [DW-1:0]                       rdata;
    logic                                irq;
    logic                                bus_err;

    logic [7:0]    ref_mem [4*sp_mem_pkg::MEM_WORDS];
    bus_result_t   exp_q[$];
    bus_result_t   got_q[$];
    logic [31:0]   lfsr_state;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    sp_bram dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (enable),
        .i_wr_en   (wr_en),
        .i_addr    (addr),
        .i_data    (wdata),
        .i_be      (be),
        .o_ready   (ready),
        .o_data    (rdata),
        .o_irq     (irq),
        .o_bus_err (bus_err)
    );

    task automatic abort_test();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_test();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_test();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_test();
        end
    endtask

    // 32-bit Galois form, taps 32 31 29 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    // access size in bytes, 0 for a bad i_be code
    function automatic int access_bytes(input logic [3:0] be_in);
        case (be_in)
            sp_mem_pkg::BE_BYTE: return 1;
            sp_mem_pkg::BE_HALF: return 2;
            sp_mem_pkg::BE_WORD: return 4;
            default:             return 0;
        endcase
    endfunction

    function automatic logic access_error(input logic [31:0] a, input logic [3:0] be_in);
        int n;
        n = access_bytes(be_in);
        return (n == 0) || ((a % n) != 0);
    endfunction

    function automatic logic [DW-1:0] expected_read(input logic [31:0] a,
                                                   input logic [3:0] be_in);
        logic [DW-1:0] v;
        int            base;
        v    = '0;
        base = a[sp_mem_pkg::WORD_AW+1:0];
        for (int i = 0; i < access_bytes(be_in); i++)
        begin
            v[8*i +: 8] = ref_mem[base+i];
        end
        return v;
    endfunction

    task automatic bus_cycle(input logic w, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] be_in);
        bus_result_t exp_r;
        bus_result_t got_r;
        int          edges;
        int          base;
        exp_r         = '0;
        got_r         = '0;
        exp_r.is_read = !w;
        exp_r.err     = access_error(a, be_in);
        exp_r.edges   = exp_r.err ? 1 : (w ? 2 : 3);
        base          = a[sp_mem_pkg::WORD_AW+1:0];
        if (!w && !exp_r.err)
        begin
            exp_r.data = expected_read(a, be_in);
        end
        if (w && !exp_r.err)
        begin
            for (int i = 0; i < access_bytes(be_in); i++)
            begin
                ref_mem[base+i] = d[8*i +: 8];
            end
        end
        exp_q.push_back(exp_r);

        @(posedge clk);
        #1;
        enable = 1'b1;
        wr_en  = w;
        addr   = a;
        wdata  = d;
        be     = be_in;
        edges  = 0;
        while (edges < MAX_WAIT)
        begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (ready)
            begin
                break;
            end
        end
        if (!ready)
        begin
            $display("timeout: no o_ready within %0d cycles, addr %h", MAX_WAIT, a);
            abort_test();
        end
        got_r.is_read = !w;
        got_r.err     = bus_err;
        got_r.data    = rdata;
        got_r.edges   = edges;

        @(posedge clk);
        #1 enable = 1'b0;
        @(negedge clk);
        got_r.err_after = bus_err;
        @(posedge clk);
        @(negedge clk);
        got_r.ready_after = ready;
        got_q.push_back(got_r);
    endtask

    // compares each finished command with its expected entry
    always @(negedge clk)
    begin
        bus_result_t got_r;
        bus_result_t exp_r;
        if (dut.u_sva.fail_count != 0)
        begin
            $display("a protocol assertion failed, see the error above");
            abort_test();
        end
        if (got_q.size() != 0)
        begin
            got_r = got_q.pop_front();
            if (exp_q.size() == 0)
            begin
                $display("bus result seen with no expected entry queued");
                abort_test();
            end
            else
            begin
                exp_r = exp_q.pop_front();
                check_flag("o_bus_err", got_r.err, exp_r.err);
                check_count("o_ready latency", got_r.edges, exp_r.edges);
                if (exp_r.is_read && !exp_r.err)
                begin
                    check_data("o_data", got_r.data, exp_r.data);
                end
                check_flag("o_bus_err after enable low", got_r.err_after, 1'b0);
                check_flag("o_ready after enable low", got_r.ready_after, 1'b0);
            end
        end
    end

    initial
    begin
        logic [31:0] r_wr;
        logic [31:0] r_size;
        logic [31:0] r_off;
        logic [31:0] r_word;
        logic [31:0] r_data;
        logic [31:0] r_be;
        logic [3:0]  be_sel;
        int          wait_cnt;
        enable     = 1'b0;
        wr_en      = 1'b0;
        addr       = '0;
        wdata      = '0;
        be         = '0;
        lfsr_state = 32'ha8bb_6bab;

        wait_cnt = 0;
        while (!rst_n && wait_cnt < MAX_WAIT)
        begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!rst_n)
        begin
            $display("reset was never released");
            abort_test();
        end

        // known contents in the first 64 words
        for (int w = 0; w < 64; w++)
        begin
            bus_cycle(1'b1, w * 4, fill_word(w * 4), sp_mem_pkg::BE_WORD);
        end

        for (int i = 0; i < 4; i++)
        begin
            bus_cycle(1'b1, i * 32'h44, 32'h1234_5678 ^ (i * 32'h0f1e_2d3c), sp_mem_pkg::BE_WORD);
        end
        for (int i = 0; i < 4; i++)
        begin
            bus_cycle(1'b0, i * 32'h44, 32'h0, sp_mem_pkg::BE_WORD);
        end

        // byte merge in word 0x40
        for (int i = 0; i < 4; i++)
        begin
            bus_cycle(1'b1, 32'h40 + i, 32'hffff_ff11 * (i + 1), sp_mem_pkg::BE_BYTE);
        end
        bus_cycle(1'b0, 32'h40, 32'h0, sp_mem_pkg::BE_WORD);
        for (int i = 0; i < 4; i++)
        begin
            bus_cycle(1'b0, 32'h40 + i, 32'h0, sp_mem_pkg::BE_BYTE);
        end

        bus_cycle(1'b1, 32'h50, 32'hdead_a5c3, sp_mem_pkg::BE_HALF);
        bus_cycle(1'b1, 32'h52, 32'hbeef_7e81, sp_mem_pkg::BE_HALF);
        bus_cycle(1'b0, 32'h50, 32'h0, sp_mem_pkg::BE_WORD);
        bus_cycle(1'b0, 32'h50, 32'h0, sp_mem_pkg::BE_HALF);
        bus_cycle(1'b0, 32'h52, 32'h0, sp_mem_pkg::BE_HALF);

        // rejected commands leave the memory alone
        bus_cycle(1'b1, 32'h61, 32'h0bad_0001, sp_mem_pkg::BE_WORD);
        bus_cycle(1'b1, 32'h65, 32'h0bad_0002, sp_mem_pkg::BE_HALF);
        bus_cycle(1'b1, 32'h67, 32'h0bad_0003, sp_mem_pkg::BE_HALF);
        bus_cycle(1'b1, 32'h60, 32'h0bad_0004, 4'b0111);
        bus_cycle(1'b0, 32'h60, 32'h0, sp_mem_pkg::BE_WORD);
        bus_cycle(1'b0, 32'h64, 32'h0, sp_mem_pkg::BE_WORD);

        for (int n = 0; n < 200; n++)
        begin
            draw_bits(1, r_wr);
            draw_bits(2, r_size);
            draw_bits(2, r_off);
            draw_bits(6, r_word);
            draw_bits(32, r_data);
            case (r_size[1:0])
                2'd0: be_sel = sp_mem_pkg::BE_BYTE;
                2'd1: be_sel = sp_mem_pkg::BE_HALF;
                2'd2: be_sel = sp_mem_pkg::BE_WORD;
                default:
                begin
                    draw_bits(4, r_be);
                    be_sel = r_be[3:0];
                    if (access_bytes(be_sel) != 0)
                    begin
                        be_sel = be_sel ^ 4'b0100;   // turn a legal code into a bad one
                    end
                end
            endcase
            bus_cycle(r_wr[0], {24'b0, r_word[5:0], r_off[1:0]}, r_data, be_sel);
        end

        wait_cnt = 0;
        while (got_q.size() != 0 && wait_cnt < MAX_WAIT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (dut.u_sva.fail_count != 0)
        begin
            $display("a protocol assertion failed during the run");
            abort_test();
        end
        if (got_q.size() != 0 || exp_q.size() != 0)
        begin
            $display("commands left unchecked at the end of the test");
            abort_test();
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* test/sp_bram_sva.sv */
/*
  strobe bus protocol assertions for the scratch memory
  bound to the top level, watches ready, error and the lane strobes
*/
module sp_bram_sva (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          i_enable,
    input logic                          i_ready,
    input logic                          i_irq,
    input logic                          i_bus_err,
    input logic                          i_error,
    input logic [sp_mem_pkg::LANES-1:0]  i_wren
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // failed assertions so far

    a_irq_low: assert property (@(posedge clk) disable iff (!rst_n) !i_irq)
        else
        begin
            $error("o_irq went high");
            fail_count++;
        end

    // ready must drop at the first edge with enable low
    a_ready_falls: assert property (@(posedge clk) disable iff (!rst_n)
        !i_enable |=> !i_ready)
        else
        begin
            $error("o_ready still high one cycle after i_enable fell");
            fail_count++;
        end

    a_no_wren_on_err: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_error && (i_wren != '0)))
        else
        begin
            $error("lane write strobe raised on a rejected command");
            fail_count++;
        end

    // an error only shows while enable is held and ready is up
    a_err_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        i_bus_err |-> i_enable && i_ready)
        else
        begin
            $error("o_bus_err high without i_enable and o_ready");
            fail_count++;
        end

endmodule

bind sp_bram sp_bram_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_enable  (i_enable),
    .i_ready   (o_ready),
    .i_irq     (o_irq),
    .i_bus_err (o_bus_err),
    .i_error   (error),
    .i_wren    (wr.wren)
);

/* test/tb_clk_gen.sv */
/*
  testbench clock and reset
  10 ns clock, active-low reset held for 4 cycles
*/
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;   // released just after the 4th edge
    end

endmodule

/* design/sp_bram.sv */
/*
  byte-addressable scratch memory on the strobe bus
  four byte-wide lane RAMs behind a request controller that adds
  byte and halfword access, plus a read aligner
*/
module sp_bram (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_enable,
    input  logic                               i_wr_en,
    input  logic [sp_mem_pkg::ADDR_WIDTH-1:0]  i_addr,
    input  logic [sp_mem_pkg::DATA_WIDTH-1:0]  i_data,
    input  logic [sp_mem_pkg::LANES-1:0]       i_be,
    output logic                               o_ready,
    output logic [sp_mem_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                               o_irq,
    output logic                               o_bus_err
);

    sp_mem_pkg::lane_req_t   req;
    sp_mem_pkg::lane_wr_t    wr;
    wire sp_mem_pkg::mem_word_u rd_word;   // one byte per lane RAM
    logic                    capture;
    logic                    error;

    lane_request_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .i_be      (i_be),
        .o_req     (req),
        .o_wr      (wr),
        .o_capture (capture),
        .o_ready   (o_ready),
        .o_error   (error)
    );

    for (genvar k = 0; k < sp_mem_pkg::LANES; k++)
    begin : g_lane
        byte_lane_ram u_lane (
            .clk    (clk),
            .i_addr (req.word_idx),
            .i_we   (wr.wren[k]),
            .i_din  (wr.data.bytes[k]),
            .o_dout (rd_word.bytes[k])
        );
    end

    read_lane_align u_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_capture (capture),
        .i_req     (req),
        .i_word    (rd_word),
        .o_data    (o_data)
    );

    assign o_irq     = 1'b0;                 // no interrupt sources
    assign o_bus_err = error & i_enable;

endmodule

/* design/read_lane_align.sv */
/*
  read aligner
  picks the addressed bytes out of the lane outputs and returns
  them zero-extended in the low bits, latched on capture
*/
module read_lane_align (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_capture,
    input  sp_mem_pkg::lane_req_t              i_req,
    input  sp_mem_pkg::mem_word_u              i_word,
    output logic [sp_mem_pkg::DATA_WIDTH-1:0]  o_data
);

    logic [sp_mem_pkg::DATA_WIDTH-1:0] aligned;

    always_comb
    begin
        case (i_req.size)
            sp_mem_pkg::SIZE_WORD:
            begin
                aligned = i_word.word;
            end
            sp_mem_pkg::SIZE_HALF:
            begin
                // only offsets 0 and 2 get this far
                if (i_req.offset[1])
                begin
                    aligned = {16'b0, i_word.word[31:16]};
                end
                else
                begin
                    aligned = {16'b0, i_word.word[15:0]};
                end
            end
            default:
            begin
                aligned = {24'b0, i_word.bytes[i_req.offset]};
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            o_data <= '0;
        end
        else if (i_capture)
        begin
            o_data <= aligned;
        end
    end

endmodule

/* design/lane_request_ctrl.sv */
/*
  request controller for the scratch memory
  takes one strobe bus command per enable pulse, decodes size and
  offset, rejects bad commands at once and steers write bytes
  onto the lanes; reads wait one cycle on the lane RAMs
*/
module lane_request_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 i_enable,
    input  logic                                 i_wr_en,
    input  logic [sp_mem_pkg::ADDR_WIDTH-1:0]    i_addr,
    input  logic [sp_mem_pkg::DATA_WIDTH-1:0]    i_data,
    input  logic [sp_mem_pkg::LANES-1:0]         i_be,
    output sp_mem_pkg::lane_req_t                o_req,
    output sp_mem_pkg::lane_wr_t                 o_wr,
    output logic                                 o_capture,
    output logic                                 o_ready,
    output logic                                 o_error
);

    logic [1:0]                    state;
    logic [1:0]                    offset;
    logic [1:0]                    size_d;
    logic                          be_ok;
    logic                          misalign;
    logic                          cmd_err;
    sp_mem_pkg::mem_word_u         wdata;
    logic [sp_mem_pkg::LANES-1:0]  wmask;

    assign offset = i_addr[1:0];

    // size class from i_be
    always_comb
    begin
        be_ok  = 1'b1;
        size_d = sp_mem_pkg::SIZE_BYTE;
        case (i_be)
            sp_mem_pkg::BE_BYTE: size_d = sp_mem_pkg::SIZE_BYTE;
            sp_mem_pkg::BE_HALF: size_d = sp_mem_pkg::SIZE_HALF;
            sp_mem_pkg::BE_WORD: size_d = sp_mem_pkg::SIZE_WORD;
            default:             be_ok  = 1'b0;   // no other pattern is legal
        endcase
    end

    // halfwords need an even offset, words offset 0
    assign misalign = ((size_d == sp_mem_pkg::SIZE_HALF) && offset[0]) ||
                      ((size_d == sp_mem_pkg::SIZE_WORD) && (offset != 2'b00));
    assign cmd_err  = !be_ok || misalign;

    // place the right-aligned bus data into the addressed lanes
    always_comb
    begin
        wdata.word = '0;
        wmask      = '0;
        case (size_d)
            sp_mem_pkg::SIZE_WORD:
            begin
                wdata.word = i_data;
                wmask      = 4'b1111;
            end
            sp_mem_pkg::SIZE_HALF:
            begin
                if (offset[1])
                begin
                    wdata.bytes[2] = i_data[7:0];
                    wdata.bytes[3] = i_data[15:8];
                    wmask          = 4'b1100;
                end
                else
                begin
                    wdata.bytes[0] = i_data[7:0];
                    wdata.bytes[1] = i_data[15:8];
                    wmask          = 4'b0011;
                end
            end
            default:
            begin
                wdata.bytes[offset] = i_data[7:0];
                wmask               = 4'b0001 << offset;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= sp_mem_pkg::ST_ISSUE;
            o_req     <= '0;
            o_wr.wren <= '0;
            o_capture <= 1'b0;
            o_ready   <= 1'b0;
            o_error   <= 1'b0;
        end
        else if (i_enable && !o_ready)
        begin
            case (state)
                sp_mem_pkg::ST_ISSUE:
                begin
                    o_req.word_idx <= i_addr[sp_mem_pkg::WORD_AW+1:2];
                    o_req.offset   <= offset;
                    o_req.size     <= size_d;
                    if (cmd_err)
                    begin
                        // memory untouched, answer right away
                        o_error <= 1'b1;
                        o_ready <= 1'b1;
                    end
                    else if (i_wr_en)
                    begin
                        o_wr.wren <= wmask;
                        o_wr.data <= wdata;
                        state     <= sp_mem_pkg::ST_RETIRE;   // lanes write next cycle
                    end
                    else
                    begin
                        state <= sp_mem_pkg::ST_DELAY;
                    end
                end
                sp_mem_pkg::ST_DELAY:
                begin
                    o_capture <= 1'b1;        // lane outputs valid after this edge
                    state     <= sp_mem_pkg::ST_RETIRE;
                end
                sp_mem_pkg::ST_RETIRE:
                begin
                    o_ready   <= 1'b1;
                    o_wr.wren <= '0;
                    o_capture <= 1'b0;
                end
                default: state <= sp_mem_pkg::ST_ISSUE;
            endcase
        end
        else if (!i_enable)
        begin
            // master dropped enable, back to idle
            state     <= sp_mem_pkg::ST_ISSUE;
            o_wr.wren <= '0;
            o_capture <= 1'b0;
            o_ready   <= 1'b0;
            o_error   <= 1'b0;
        end
    end

endmodule

/* design/byte_lane_ram.sv */
/*
  one byte lane of the scratch store
  single port, synchronous write, registered read of the same address
*/
module byte_lane_ram (
    input  logic                             clk,
    input  logic [sp_mem_pkg::WORD_AW-1:0]   i_addr,
    input  logic                             i_we,
    input  logic [7:0]                       i_din,
    output logic [7:0]                       o_dout
);

    // contents survive reset
    logic [7:0] mem [sp_mem_pkg::MEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_addr] <= i_din;
        end
        o_dout <= mem[i_addr];   // old data on a write cycle
    end

endmodule

/* design/sp_mem_pkg.sv */
/*
  scratch memory package
  bus and store sizes, access size codes, the access request,
  the per-lane write bundle and the memory word seen as word or bytes
*/
package sp_mem_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LANES      = DATA_WIDTH / 8;

    // store depth, per lane
    localparam int MEM_WORDS = 1024;
    localparam int WORD_AW   = $clog2(MEM_WORDS);

    // legal i_be codes, these give the size and not a lane mask
    localparam logic [LANES-1:0] BE_BYTE = 4'b0001;
    localparam logic [LANES-1:0] BE_HALF = 4'b0011;
    localparam logic [LANES-1:0] BE_WORD = 4'b1111;

    // decoded access class
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // request FSM states
    localparam logic [1:0] ST_ISSUE  = 2'd0;
    localparam logic [1:0] ST_DELAY  = 2'd1;
    localparam logic [1:0] ST_RETIRE = 2'd2;

    // one memory word, lane 0 in the low byte
    typedef union packed {
        logic [DATA_WIDTH-1:0]   word;
        logic [LANES-1:0][7:0]   bytes;
    } mem_word_u;

    // command as latched in the issue cycle
    typedef struct packed {
        logic [WORD_AW-1:0] word_idx;   // word address into every lane
        logic [1:0]         offset;     // byte offset within the word
        logic [1:0]         size;       // SIZE_BYTE / SIZE_HALF / SIZE_WORD
    } lane_req_t;

    // write strobes and steered data for the lane RAMs
    typedef struct packed {
        logic [LANES-1:0] wren;
        mem_word_u        data;
    } lane_wr_t;

endpackage
